// ==== ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Execute stage configuration
////////////////////////////////////////////////////////////////////////////

// Integer data path width
`define EX_XLEN 32

// Busy cycles after a multiply is accepted
`define EX_MULT_CYCLES 5

// Busy cycles after a divide is accepted
`define EX_DIV_CYCLES 10

`endif

// ==== ex_pkg.sv ====
package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// Same 32 bits, read as either format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll   = 6'h00,
		fn_srl   = 6'h02,
		fn_sra   = 6'h03,
		fn_mfhi  = 6'h10,
		fn_mthi  = 6'h11,
		fn_mflo  = 6'h12,
		fn_mtlo  = 6'h13,
		fn_mult  = 6'h18,
		fn_multu = 6'h19,
		fn_div   = 6'h1a,
		fn_divu  = 6'h1b,
		fn_addu  = 6'h21,
		fn_subu  = 6'h23,
		fn_and   = 6'h24,
		fn_or    = 6'h25,
		fn_xor   = 6'h26,
		fn_nor   = 6'h27,
		fn_slt   = 6'h2a,
		fn_sltu  = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

	typedef enum logic [2:0] {
		md_none, md_mult, md_multu, md_div, md_divu, md_mthi, md_mtlo
	} md_op_e;

	// Where the written value comes from
	typedef enum logic [1:0] {
		res_alu, res_hi, res_lo
	} res_sel_e;

endpackage

// ==== ex_decode.sv ====
`timescale 1ns/1ps

module ex_decode
	import ex_pkg::*;
(
	input  instr_t   instr,
	output alu_op_e  alu_op,
	output logic     imm_sel,
	output logic     imm_zero_ext,
	output md_op_e   md_op,
	output res_sel_e res_sel,
	output logic     writes_reg,
	output logic     [4:0] dest_reg
);

	always_comb begin
		// Non-writing no-op unless an encoding below matches
		alu_op       = alu_add;
		imm_sel      = 1'b0;
		imm_zero_ext = 1'b0;
		md_op        = md_none;
		res_sel      = res_alu;
		writes_reg   = 1'b0;
		dest_reg     = instr.r.rd;

		if (instr.r.opcode == op_special) begin
			writes_reg = 1'b1;
			case (instr.r.funct)
				fn_sll:   alu_op = alu_sll;
				fn_srl:   alu_op = alu_srl;
				fn_sra:   alu_op = alu_sra;
				fn_addu:  alu_op = alu_add;
				fn_subu:  alu_op = alu_sub;
				fn_and:   alu_op = alu_and;
				fn_or:    alu_op = alu_or;
				fn_xor:   alu_op = alu_xor;
				fn_nor:   alu_op = alu_nor;
				fn_slt:   alu_op = alu_slt;
				fn_sltu:  alu_op = alu_sltu;
				fn_mfhi:  res_sel = res_hi;
				fn_mflo:  res_sel = res_lo;
				// HI/LO writers produce no register result
				fn_mthi:  begin md_op = md_mthi;  writes_reg = 1'b0; end
				fn_mtlo:  begin md_op = md_mtlo;  writes_reg = 1'b0; end
				fn_mult:  begin md_op = md_mult;  writes_reg = 1'b0; end
				fn_multu: begin md_op = md_multu; writes_reg = 1'b0; end
				fn_div:   begin md_op = md_div;   writes_reg = 1'b0; end
				fn_divu:  begin md_op = md_divu;  writes_reg = 1'b0; end
				default:  writes_reg = 1'b0;
			endcase
		end else begin
			// I-type, result goes to rt
			dest_reg   = instr.i.rt;
			imm_sel    = 1'b1;
			writes_reg = 1'b1;
			case (instr.i.opcode)
				op_addiu: alu_op = alu_add;
				op_slti:  alu_op = alu_slt;
				op_sltiu: alu_op = alu_sltu;
				op_andi:  begin alu_op = alu_and; imm_zero_ext = 1'b1; end
				op_ori:   begin alu_op = alu_or;  imm_zero_ext = 1'b1; end
				op_xori:  begin alu_op = alu_xor; imm_zero_ext = 1'b1; end
				op_lui:   alu_op = alu_lui;
				default: begin
					imm_sel    = 1'b0;
					writes_reg = 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_alu
	import ex_pkg::*;
(
	input  alu_op_e              op,
	input  logic [`EX_XLEN-1:0] a,
	input  logic [`EX_XLEN-1:0] b,
	input  logic [4:0]          shamt,
	output logic [`EX_XLEN-1:0] y
);

	logic lt_s;
	logic lt_u;
	logic [`EX_XLEN-1:0] sum;
	logic [`EX_XLEN-1:0] diff;

	////////////////////////////////////////////////////////////////////////////
	// Shared arithmetic
	////////////////////////////////////////////////////////////////////////////

	assign sum  = a + b;
	assign diff = a - b;

	// Compares are plain magnitude checks, no overflow trap
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	////////////////////////////////////////////////////////////////////////////
	// Result mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		y = '0;
		case (op)
			alu_add:  y = sum;
			alu_sub:  y = diff;
			alu_and:  y = a & b;
			alu_or:   y = a | b;
			alu_xor:  y = a ^ b;
			alu_nor:  y = ~(a | b);
			alu_slt:  y = {{(`EX_XLEN-1){1'b0}}, lt_s};
			alu_sltu: y = {{(`EX_XLEN-1){1'b0}}, lt_u};
			// MIPS shifts act on rt, which arrives as b
			alu_sll:  y = b << shamt;
			alu_srl:  y = b >> shamt;
			alu_sra:  y = $signed(b) >>> shamt;
			// Immediate into the upper half
			alu_lui:  y = {b[15:0], {(`EX_XLEN-16){1'b0}}};
			default:  y = '0;
		endcase
	end

endmodule

// ==== ex_muldiv.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_muldiv
	import ex_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  md_op_e              op,
	input  logic [`EX_XLEN-1:0] a,
	input  logic [`EX_XLEN-1:0] b,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo,
	output logic                busy
);

	localparam int cnt_w = $clog2(`EX_DIV_CYCLES + 1);

	logic [cnt_w-1:0]           cnt;
	logic [`EX_XLEN-1:0]        pend_hi;
	logic [`EX_XLEN-1:0]        pend_lo;
	logic [`EX_XLEN-1:0]        nxt_hi;
	logic [`EX_XLEN-1:0]        nxt_lo;
	logic signed [2*`EX_XLEN-1:0] prod_s;
	logic [2*`EX_XLEN-1:0]      prod_u;
	logic                       div_zero;
	logic                       div_ovf;

	////////////////////////////////////////////////////////////////////////////
	// Result computed at start
	////////////////////////////////////////////////////////////////////////////

	assign prod_s   = $signed(a) * $signed(b);
	assign prod_u   = a * b;
	assign div_zero = (b == '0);
	// Most negative over minus one
	assign div_ovf  = (a == {1'b1, {(`EX_XLEN-1){1'b0}}}) && (b == '1);

	always_comb begin
		nxt_hi = '0;
		nxt_lo = '0;
		case (op)
			md_mult:  {nxt_hi, nxt_lo} = prod_s;
			md_multu: {nxt_hi, nxt_lo} = prod_u;
			md_div: begin
				if (div_zero) begin
					nxt_hi = a;
					nxt_lo = '1;
				end else if (div_ovf) begin
					nxt_hi = '0;
					nxt_lo = a;
				end else begin
					// Quotient truncates, remainder follows the dividend's sign
					nxt_lo = $signed(a) / $signed(b);
					nxt_hi = $signed(a) % $signed(b);
				end
			end
			md_divu: begin
				if (div_zero) begin
					nxt_hi = a;
					nxt_lo = '1;
				end else begin
					nxt_lo = a / b;
					nxt_hi = a % b;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (start) begin
			pend_hi <= nxt_hi;
			pend_lo <= nxt_lo;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Busy countdown and architectural HI/LO
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			hi  <= '0;
			lo  <= '0;
		end else if (start) begin
			case (op)
				md_mult, md_multu: cnt <= cnt_w'(`EX_MULT_CYCLES);
				md_div, md_divu:   cnt <= cnt_w'(`EX_DIV_CYCLES);
				md_mthi:           hi <= a;
				md_mtlo:           lo <= a;
				default: ;
			endcase
		end else if (cnt != '0) begin
			cnt <= cnt - cnt_w'(1);
			// Commit on the edge that ends the busy period
			if (cnt == cnt_w'(1)) begin
				hi <= pend_hi;
				lo <= pend_lo;
			end
		end
	end

	assign busy = (cnt != '0);

	// Issue logic upstream must hold off while busy
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

	// No busy period outlasts the divide latency
	a_busy_bounded: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> ##[1:`EX_DIV_CYCLES] !busy);

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage
	import ex_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [31:0]         instr,
	input  logic [`EX_XLEN-1:0] rs_data,
	input  logic [`EX_XLEN-1:0] rt_data,
	output logic                in_ready,
	output logic                result_valid,
	output logic [`EX_XLEN-1:0] result,
	output logic [4:0]          result_reg
);

	instr_t              instr_u;
	alu_op_e             alu_op;
	logic                imm_sel;
	logic                imm_zero_ext;
	md_op_e              md_op;
	res_sel_e            res_sel;
	logic                writes_reg;
	logic [4:0]          dest_reg;
	logic                accept;
	logic                md_busy;
	logic [`EX_XLEN-1:0] imm_ext;
	logic [`EX_XLEN-1:0] opnd_b;
	logic [`EX_XLEN-1:0] alu_result;
	logic [`EX_XLEN-1:0] hi;
	logic [`EX_XLEN-1:0] lo;
	logic [`EX_XLEN-1:0] wb_data;

	assign instr_u  = instr;
	assign in_ready = !md_busy;
	assign accept   = in_valid && in_ready;

	ex_decode u_decode (
		.instr(instr_u), .alu_op(alu_op), .imm_sel(imm_sel), .imm_zero_ext(imm_zero_ext),
		.md_op(md_op), .res_sel(res_sel), .writes_reg(writes_reg), .dest_reg(dest_reg)
	);

	////////////////////////////////////////////////////////////////////////////
	// Operands and result select
	////////////////////////////////////////////////////////////////////////////

	assign imm_ext = imm_zero_ext ? {{(`EX_XLEN-16){1'b0}}, instr_u.i.imm}
		: {{(`EX_XLEN-16){instr_u.i.imm[15]}}, instr_u.i.imm};
	assign opnd_b  = imm_sel ? imm_ext : rt_data;

	ex_alu u_alu (
		.op(alu_op), .a(rs_data), .b(opnd_b), .shamt(instr_u.r.shamt), .y(alu_result)
	);

	ex_muldiv u_muldiv (
		.clk(clk), .rst(rst), .start(accept), .op(md_op), .a(rs_data), .b(rt_data),
		.hi(hi), .lo(lo), .busy(md_busy)
	);

	always_comb begin
		case (res_sel)
			res_hi:  wb_data = hi;
			res_lo:  wb_data = lo;
			default: wb_data = alu_result;
		endcase
	end

	// One-stage result register
	always_ff @(posedge clk) begin
		if (rst) result_valid <= 1'b0;
		else     result_valid <= accept && writes_reg;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result     <= wb_data;
			result_reg <= dest_reg;
		end
	end

	a_valid_after_accept: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(accept));

endmodule

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_ex_stage
	import ex_pkg::*;
();

	localparam int alu_rounds = 6;
	localparam int total_ops  = 4 + alu_rounds * 18 + 5 * 3 + 6 * 3 + 4 + 3;
	localparam int wd_ns      = (10 + total_ops * (`EX_DIV_CYCLES + 4)) * 8 + 2000;

	logic        clk = 1'b0;
	logic        rst;
	logic        in_valid;
	logic [31:0] instr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic        in_ready;
	logic        result_valid;
	logic [31:0] result;
	logic [4:0]  result_reg;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_err0 = 0;
	int          cycle = 0;
	int          accept_cyc = 0;

	always #4 clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	ex_stage dut_i (
		.clk(clk), .rst(rst), .in_valid(in_valid), .instr(instr), .rs_data(rs_data),
		.rt_data(rt_data), .in_ready(in_ready), .result_valid(result_valid),
		.result(result), .result_reg(result_reg)
	);

	////////////////////////////////////////////////////////////////////////////
	// Instruction builders and reference models
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_instr(input funct_e fn, input logic [4:0] rd,
		input logic [4:0] sh);
		return {op_special, 5'd1, 5'd2, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_instr(input opcode_e op, input logic [4:0] rt,
		input logic [15:0] imm);
		return {op, 5'd1, rt, imm};
	endfunction

	// 64-bit product with HI in the upper word
	function automatic logic [63:0] mul_model(input bit sgn, input logic [31:0] a,
		input logic [31:0] b);
		longint sa;
		longint sb;
		sa = sgn ? longint'($signed(a)) : longint'({32'h0, a});
		sb = sgn ? longint'($signed(b)) : longint'({32'h0, b});
		return sa * sb;
	endfunction

	// Remainder in the upper word and quotient in the lower
	function automatic logic [63:0] div_model(input bit sgn, input logic [31:0] a,
		input logic [31:0] b);
		int q;
		int r;
		if (b == 32'h0) return {a, 32'hffff_ffff};
		if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) return {32'h0, a};
		if (!sgn) return {a - (a / b) * b, a / b};
		q = $signed(a) / $signed(b);
		r = $signed(a) - q * $signed(b);
		return {r, q};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Holds the instruction until the edge that accepts it
	task automatic issue(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		in_valid <= 1'b1;
		instr    <= ins;
		rs_data  <= a;
		rt_data  <= b;
		do begin
			@(negedge clk);
			// Nothing completes while the instruction is held back
			if (!in_ready)
				check("stalled issue valid", 32'd0, {31'd0, result_valid});
		end while (!in_ready);
		accept_cyc = cycle;
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic expect_result(input string name, input logic [31:0] exp, input logic [4:0] rd);
		@(negedge clk);
		check({name, " valid"}, 32'd1, {31'd0, result_valid});
		check(name, exp, result);
		check({name, " reg"}, {27'd0, rd}, {27'd0, result_reg});
	endtask

	task automatic expect_no_result(input string name);
		@(negedge clk);
		check({name, " valid"}, 32'd0, {31'd0, result_valid});
		check({name, " ready"}, 32'd1, {31'd0, in_ready});
	endtask

	// Counts cycles with in_ready low after an acceptance
	task automatic wait_busy(input string name, input int cycles);
		int n = 0;
		do begin
			@(negedge clk);
			check({name, " valid"}, 32'd0, {31'd0, result_valid});
			if (!in_ready) n++;
		end while (!in_ready);
		check({name, " busy cycles"}, cycles, n);
	endtask

	task automatic alu(input string name, input logic [31:0] ins, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] exp, input logic [4:0] rd);
		issue(ins, a, b);
		expect_result(name, exp, rd);
	endtask

	task automatic md_case(input string name, input funct_e fn, input logic [31:0] a,
		input logic [31:0] b, input int cycles, input logic [63:0] exp);
		issue(r_instr(fn, 5'd0, 5'd0), a, b);
		wait_busy(name, cycles);
		alu({name, " hi"}, r_instr(fn_mfhi, 5'd2, 5'd0), 0, 0, exp[63:32], 5'd2);
		alu({name, " lo"}, r_instr(fn_mflo, 5'd3, 5'd0), 0, 0, exp[31:0], 5'd3);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %s", name, (errors == test_err0) ? "ok" : "errors found");
		test_err0 = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge clk);
		check("reset ready", 32'd1, {31'd0, in_ready});
		check("reset valid", 32'd0, {31'd0, result_valid});
		// Nonzero operands keep the ALU path apart from HI and LO
		alu("reset mfhi", r_instr(fn_mfhi, 5'd4, 5'd0), 32'h0000_1357, 32'h0000_2468,
			32'h0, 5'd4);
		alu("reset mflo", r_instr(fn_mflo, 5'd5, 5'd0), 32'h0000_1357, 32'h0000_2468,
			32'h0, 5'd5);
		end_test("reset");
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] si;
		logic [31:0] zi;
		logic [15:0] imm;
		logic [4:0]  sh;
		logic [4:0]  rd;
		for (int i = 0; i < alu_rounds; i++) begin
			a   = $urandom;
			b   = (i == 0) ? a : $urandom;
			imm = 16'($urandom);
			sh  = 5'($urandom);
			rd  = 5'($urandom % 31 + 1);
			si  = {{16{imm[15]}}, imm};
			zi  = {16'h0, imm};
			alu("addu", r_instr(fn_addu, rd, 5'd0), a, b, a + b, rd);
			alu("subu", r_instr(fn_subu, rd, 5'd0), a, b, a - b, rd);
			alu("and", r_instr(fn_and, rd, 5'd0), a, b, a & b, rd);
			alu("or", r_instr(fn_or, rd, 5'd0), a, b, a | b, rd);
			alu("xor", r_instr(fn_xor, rd, 5'd0), a, b, a ^ b, rd);
			alu("nor", r_instr(fn_nor, rd, 5'd0), a, b, ~(a | b), rd);
			alu("slt", r_instr(fn_slt, rd, 5'd0), a, b,
				($signed(a) < $signed(b)) ? 32'd1 : 32'd0, rd);
			alu("sltu", r_instr(fn_sltu, rd, 5'd0), a, b, (a < b) ? 32'd1 : 32'd0, rd);
			alu("sll", r_instr(fn_sll, rd, sh), a, b, b << sh, rd);
			alu("srl", r_instr(fn_srl, rd, sh), a, b, b >> sh, rd);
			alu("sra", r_instr(fn_sra, rd, sh), a, b, 32'($signed(b) >>> sh), rd);
			alu("addiu", i_instr(op_addiu, rd, imm), a, b, a + si, rd);
			alu("slti", i_instr(op_slti, rd, imm), a, b,
				($signed(a) < $signed(si)) ? 32'd1 : 32'd0, rd);
			alu("sltiu", i_instr(op_sltiu, rd, imm), a, b, (a < si) ? 32'd1 : 32'd0, rd);
			alu("andi", i_instr(op_andi, rd, imm), a, b, a & zi, rd);
			alu("ori", i_instr(op_ori, rd, imm), a, b, a | zi, rd);
			alu("xori", i_instr(op_xori, rd, imm), a, b, a ^ zi, rd);
			alu("lui", i_instr(op_lui, rd, imm), a, b, {imm, 16'h0}, rd);
		end
		end_test("alu");
	endtask

	task automatic test_mult();
		logic [31:0] a;
		logic [31:0] b;
		a = $urandom;
		b = $urandom;
		md_case("mult rand", fn_mult, a, b, `EX_MULT_CYCLES, mul_model(1, a, b));
		md_case("multu rand", fn_multu, a, b, `EX_MULT_CYCLES, mul_model(0, a, b));
		md_case("mult neg neg", fn_mult, 32'hffff_fff9, 32'hffff_d8f1, `EX_MULT_CYCLES,
			mul_model(1, 32'hffff_fff9, 32'hffff_d8f1));
		md_case("mult min", fn_mult, 32'h8000_0000, 32'h8000_0000, `EX_MULT_CYCLES,
			mul_model(1, 32'h8000_0000, 32'h8000_0000));
		md_case("multu max", fn_multu, 32'h8000_0000, 32'hffff_ffff, `EX_MULT_CYCLES,
			mul_model(0, 32'h8000_0000, 32'hffff_ffff));
		end_test("mult");
	endtask

	task automatic test_div();
		logic [31:0] a;
		logic [31:0] b;
		a = $urandom;
		// Small divisor of either sign, so the quotient is not trivial
		b = ($urandom % 1000 + 1) * (($urandom % 2) ? -1 : 1);
		md_case("div rand", fn_div, a, b, `EX_DIV_CYCLES, div_model(1, a, b));
		md_case("divu rand", fn_divu, a, b, `EX_DIV_CYCLES, div_model(0, a, b));
		md_case("div neg", fn_div, 32'hffff_fff9, 32'd2, `EX_DIV_CYCLES,
			{32'hffff_ffff, 32'hffff_fffd});
		md_case("div zero", fn_div, a, 32'h0, `EX_DIV_CYCLES, {a, 32'hffff_ffff});
		md_case("divu zero", fn_divu, a, 32'h0, `EX_DIV_CYCLES, {a, 32'hffff_ffff});
		md_case("div ovf", fn_div, 32'h8000_0000, 32'hffff_ffff, `EX_DIV_CYCLES,
			{32'h0, 32'h8000_0000});
		end_test("div");
	endtask

	task automatic test_hilo_moves();
		logic [31:0] x;
		logic [31:0] y;
		x = $urandom;
		y = $urandom;
		issue(r_instr(fn_mthi, 5'd0, 5'd0), x, 0);
		expect_no_result("mthi");
		issue(r_instr(fn_mtlo, 5'd0, 5'd0), y, 0);
		expect_no_result("mtlo");
		alu("mfhi after mthi", r_instr(fn_mfhi, 5'd6, 5'd0), 0, 0, x, 5'd6);
		alu("mflo after mtlo", r_instr(fn_mflo, 5'd7, 5'd0), 0, 0, y, 5'd7);
		end_test("hilo moves");
	endtask

	task automatic test_backpressure();
		int c0;
		issue(r_instr(fn_mult, 5'd0, 5'd0), 32'd3, 32'd5);
		c0 = accept_cyc;
		// Addu waits behind the busy multiply
		issue(r_instr(fn_addu, 5'd9, 5'd0), 32'h1234, 32'h1111);
		check("backpressure accept", c0 + `EX_MULT_CYCLES + 1, accept_cyc);
		expect_result("backpressure addu", 32'h2345, 5'd9);
		end_test("backpressure");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hdd83db33));
		rst      = 1'b1;
		in_valid = 1'b0;
		instr    = 32'h0;
		rs_data  = 32'h0;
		rt_data  = 32'h0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_alu();
		test_mult();
		test_div();
		test_hilo_moves();
		test_backpressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		#(wd_ns);
		$display("Timeout: the tests did not finish within %0d ns", wd_ns);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_muldiv.sv
ex_stage.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_ex_stage -o sim_ex_stage || exit 1
out=$(./obj_dir/sim_ex_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1
